// File: run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f --top-module tb_periph_system \
    -Mdir obj_dir -o sim_periph_system
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output="$(./obj_dir/sim_periph_system)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qxF -- "*** PASSED ***"; then
    exit 0
fi
echo "Simulation did not pass"
exit 1

// File: src/apb_decoder.sv
`timescale 1ns/1ps

module apb_decoder import periph_pkg::*; (
    input  apb_req_t          apb_req_i,

    output logic              mem_sel_o,
    output logic              timer_sel_o,
    output logic              gpio_sel_o,

    input  logic [DATA_W-1:0] mem_rdata_i,
    input  logic [DATA_W-1:0] timer_rdata_i,
    input  logic [DATA_W-1:0] gpio_rdata_i,

    output apb_rsp_t          apb_rsp_o,
    output logic              bus_err_o
);

    slave_e slave;
    logic   access;
    logic   unmapped;

    // ==================================================
    // Address map
    // ==================================================

    always_comb begin
        if ((apb_req_i.paddr & ~(MEM_LIMIT - MEM_BASE)) == MEM_BASE) begin
            slave = SLV_MEM;
        end else if (apb_req_i.paddr[ADDR_W-1:4] == TIMER_BASE[ADDR_W-1:4]) begin
            slave = SLV_TIMER;
        end else if (apb_req_i.paddr[ADDR_W-1:4] == GPIO_BASE[ADDR_W-1:4]) begin
            slave = SLV_GPIO;
        end else begin
            slave = SLV_NONE;
        end
    end

    // Selects follow psel through both phases
    assign mem_sel_o   = apb_req_i.psel & (slave == SLV_MEM);
    assign timer_sel_o = apb_req_i.psel & (slave == SLV_TIMER);
    assign gpio_sel_o  = apb_req_i.psel & (slave == SLV_GPIO);

    // ==================================================
    // Response
    // ==================================================

    assign access   = apb_req_i.psel & apb_req_i.penable;
    assign unmapped = access & (slave == SLV_NONE);

    // Zero-wait slaves, so ready is simply the access phase
    always_comb begin
        apb_rsp_o.pready  = access;
        apb_rsp_o.pslverr = unmapped;

        case (slave)
            SLV_MEM:   apb_rsp_o.prdata = mem_rdata_i;
            SLV_TIMER: apb_rsp_o.prdata = timer_rdata_i;
            SLV_GPIO:  apb_rsp_o.prdata = gpio_rdata_i;
            default:   apb_rsp_o.prdata = '0;
        endcase
    end

    // One pulse per failed access
    assign bus_err_o = unmapped;

endmodule : apb_decoder

// File: src/gpio_port.sv
`timescale 1ns/1ps

module gpio_port import periph_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_n_i,

    input  logic                 sel_i,
    input  apb_req_t             apb_req_i,
    output logic [DATA_W-1:0]    rdata_o,

    input  logic [GPIO_PINS-1:0] pin_i,
    output logic [GPIO_PINS-1:0] pin_o,
    output logic [GPIO_PINS-1:0] pin_oe_o,
    output logic                 edge_o
);

    gpio_reg_e            offset;
    logic                 wr_en;
    logic [GPIO_PINS-1:0] out_q, dir_q;
    logic [GPIO_PINS-1:0] meta_q, sync_q, prev_q;

    assign offset = gpio_reg_e'(apb_req_i.paddr[3:2]);
    assign wr_en  = sel_i & apb_req_i.penable & apb_req_i.pwrite;

    // ==================================================
    // Registers and input synchronizer
    // ==================================================

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_q  <= '0;
            dir_q  <= '0;
            meta_q <= '0;
            sync_q <= '0;
            prev_q <= '0;
        end else begin
            meta_q <= pin_i;
            sync_q <= meta_q;
            prev_q <= sync_q;

            // IN is read-only
            if (wr_en && offset == GPIO_OUT) out_q <= apb_req_i.pwdata[GPIO_PINS-1:0];
            if (wr_en && offset == GPIO_DIR) dir_q <= apb_req_i.pwdata[GPIO_PINS-1:0];
        end
    end

    assign pin_o    = out_q;
    assign pin_oe_o = dir_q;

    // Rising edge on any input-direction pin
    assign edge_o = |(sync_q & ~prev_q & ~dir_q);

    always_comb begin
        rdata_o = '0;
        case (offset)
            GPIO_OUT: rdata_o[GPIO_PINS-1:0] = out_q;
            GPIO_DIR: rdata_o[GPIO_PINS-1:0] = dir_q;
            GPIO_IN:  rdata_o[GPIO_PINS-1:0] = sync_q;
            default:  rdata_o = '0;
        endcase
    end

endmodule : gpio_port

// File: src/irq_controller.sv
`timescale 1ns/1ps

module irq_controller import periph_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_n_i,

    input  logic [IRQ_SOURCES-1:0] src_i,
    input  logic                   ack_i,

    output logic                   irq_o,
    output irq_src_e               vector_o
);

    logic [IRQ_SOURCES-1:0] pending_q;
    logic [IRQ_SOURCES-1:0] ack_clr;
    irq_src_e               vector;

    // ==================================================
    // Priority encoder
    // ==================================================

    // Scan from the top so the lowest pending index ends up selected
    always_comb begin
        vector = IRQ_TIMER;
        for (int i = IRQ_SOURCES - 1; i >= 0; i--) begin
            if (pending_q[i]) begin
                vector = irq_src_e'(IRQ_VEC_W'(i));
            end
        end
    end

    // Only the presented vector is cleared
    always_comb begin
        ack_clr = '0;
        ack_clr[vector] = ack_i & irq_o;
    end

    // ==================================================
    // Pending bits
    // ==================================================

    // New pulse on the same edge as an ack keeps the bit set
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pending_q <= '0;
        end else begin
            pending_q <= (pending_q & ~ack_clr) | src_i;
        end
    end

    assign irq_o    = |pending_q;
    assign vector_o = vector;

endmodule : irq_controller

// File: src/periph_pkg.sv
package periph_pkg;

    // ==================================================
    // Bus widths
    // ==================================================

    localparam int DATA_W = 32;
    localparam int ADDR_W = 32;
    localparam int STRB_W = DATA_W / 8;

    // ==================================================
    // Memory map
    // ==================================================

    // 1 KiB of word-organized data memory
    localparam int MEM_WORDS = 256;
    localparam int MEM_AW    = $clog2(MEM_WORDS);

    localparam logic [ADDR_W-1:0] MEM_BASE   = 32'h0000_0000;
    localparam logic [ADDR_W-1:0] MEM_LIMIT  = 32'h0000_03FF;

    // Four-word register windows
    localparam logic [ADDR_W-1:0] TIMER_BASE = 32'h0000_1000;
    localparam logic [ADDR_W-1:0] GPIO_BASE  = 32'h0000_2000;

    // Peripheral sizes
    localparam int GPIO_PINS   = 8;
    localparam int IRQ_SOURCES = 3;
    localparam int IRQ_VEC_W   = $clog2(IRQ_SOURCES);

    // ==================================================
    // APB channel
    // ==================================================

    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [ADDR_W-1:0] paddr;
        logic [DATA_W-1:0] pwdata;
        logic [STRB_W-1:0] pstrb;
    } apb_req_t;

    typedef struct packed {
        logic              pready;
        logic [DATA_W-1:0] prdata;
        logic              pslverr;
    } apb_rsp_t;

    // ==================================================
    // Selects, register offsets, interrupt sources
    // ==================================================

    typedef enum logic [1:0] {SLV_MEM, SLV_TIMER, SLV_GPIO, SLV_NONE} slave_e;

    typedef enum logic [1:0] {TMR_CTRL = 2'd0, TMR_COMPARE = 2'd1, TMR_COUNT = 2'd2} timer_reg_e;

    typedef enum logic [1:0] {GPIO_OUT = 2'd0, GPIO_DIR = 2'd1, GPIO_IN = 2'd2} gpio_reg_e;

    // Lower index wins arbitration
    typedef enum logic [IRQ_VEC_W-1:0] {IRQ_TIMER = 2'd0, IRQ_GPIO = 2'd1, IRQ_BUS = 2'd2} irq_src_e;

endpackage : periph_pkg

// File: src/periph_system.sv
`timescale 1ns/1ps

module periph_system import periph_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_n_i,

    input  apb_req_t             apb_req_i,
    output apb_rsp_t             apb_rsp_o,

    input  logic [GPIO_PINS-1:0] gpio_in_i,
    output logic [GPIO_PINS-1:0] gpio_out_o,
    output logic [GPIO_PINS-1:0] gpio_oe_o,

    output logic                 irq_o,
    output logic [IRQ_VEC_W-1:0] irq_vector_o,
    input  logic                 irq_ack_i
);

    // Reset release synchronizer
    logic rst_meta, rst_n;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rst_meta <= 1'b0;
            rst_n    <= 1'b0;
        end else begin
            rst_meta <= 1'b1;
            rst_n    <= rst_meta;
        end
    end

    // ==================================================
    // Bus decode
    // ==================================================

    logic              mem_sel, timer_sel, gpio_sel, bus_err;
    logic [DATA_W-1:0] mem_rdata, timer_rdata, gpio_rdata;

    apb_decoder u_decoder (
        .apb_req_i     ( apb_req_i   ),
        .mem_sel_o     ( mem_sel     ),
        .timer_sel_o   ( timer_sel   ),
        .gpio_sel_o    ( gpio_sel    ),
        .mem_rdata_i   ( mem_rdata   ),
        .timer_rdata_i ( timer_rdata ),
        .gpio_rdata_i  ( gpio_rdata  ),
        .apb_rsp_o     ( apb_rsp_o   ),
        .bus_err_o     ( bus_err     )
    );

    sys_memory u_memory (
        .clk_i     ( clk_i     ),
        .rst_n_i   ( rst_n     ),
        .sel_i     ( mem_sel   ),
        .apb_req_i ( apb_req_i ),
        .rdata_o   ( mem_rdata )
    );

    // ==================================================
    // Timer
    // ==================================================

    logic              tmr_enable, tmr_load, tmr_match;
    logic [DATA_W-1:0] tmr_compare, tmr_load_value, tmr_count;

    timer_regs u_timer_regs (
        .clk_i        ( clk_i          ),
        .rst_n_i      ( rst_n          ),
        .sel_i        ( timer_sel      ),
        .apb_req_i    ( apb_req_i      ),
        .count_i      ( tmr_count      ),
        .rdata_o      ( timer_rdata    ),
        .enable_o     ( tmr_enable     ),
        .compare_o    ( tmr_compare    ),
        .load_o       ( tmr_load       ),
        .load_value_o ( tmr_load_value )
    );

    timer_core u_timer_core (
        .clk_i        ( clk_i          ),
        .rst_n_i      ( rst_n          ),
        .enable_i     ( tmr_enable     ),
        .compare_i    ( tmr_compare    ),
        .load_i       ( tmr_load       ),
        .load_value_i ( tmr_load_value ),
        .count_o      ( tmr_count      ),
        .match_o      ( tmr_match      )
    );

    // ==================================================
    // GPIO and interrupts
    // ==================================================

    logic                   gpio_edge;
    logic [IRQ_SOURCES-1:0] irq_src;
    irq_src_e               irq_vec;

    gpio_port u_gpio (
        .clk_i     ( clk_i      ),
        .rst_n_i   ( rst_n      ),
        .sel_i     ( gpio_sel   ),
        .apb_req_i ( apb_req_i  ),
        .rdata_o   ( gpio_rdata ),
        .pin_i     ( gpio_in_i  ),
        .pin_o     ( gpio_out_o ),
        .pin_oe_o  ( gpio_oe_o  ),
        .edge_o    ( gpio_edge  )
    );

    assign irq_src[IRQ_TIMER] = tmr_match;
    assign irq_src[IRQ_GPIO]  = gpio_edge;
    assign irq_src[IRQ_BUS]   = bus_err;

    irq_controller u_irq (
        .clk_i    ( clk_i     ),
        .rst_n_i  ( rst_n     ),
        .src_i    ( irq_src   ),
        .ack_i    ( irq_ack_i ),
        .irq_o    ( irq_o     ),
        .vector_o ( irq_vec   )
    );

    assign irq_vector_o = irq_vec;

endmodule : periph_system

// File: src/sys_memory.sv
`timescale 1ns/1ps

module sys_memory import periph_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_n_i,

    input  logic              sel_i,
    input  apb_req_t          apb_req_i,
    output logic [DATA_W-1:0] rdata_o
);

    logic [DATA_W-1:0] mem [MEM_WORDS];
    logic [DATA_W-1:0] rdata_q;
    logic [MEM_AW-1:0] word_idx;
    logic              wr_en;
    logic              rd_capture;

    assign word_idx = apb_req_i.paddr[MEM_AW+1:2];

    // Write in the access phase, read address taken in setup
    assign wr_en      = sel_i & apb_req_i.penable & apb_req_i.pwrite;
    assign rd_capture = sel_i & ~apb_req_i.penable & ~apb_req_i.pwrite;

    // Byte lanes
    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (apb_req_i.pstrb[b]) begin
                    mem[word_idx][b*8 +: 8] <= apb_req_i.pwdata[b*8 +: 8];
                end
            end
        end
    end

    // Output register, held through the access phase
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rdata_q <= '0;
        end else if (rd_capture) begin
            rdata_q <= mem[word_idx];
        end
    end

    assign rdata_o = rdata_q;

endmodule : sys_memory

// File: src/timer_core.sv
`timescale 1ns/1ps

module timer_core import periph_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_n_i,

    input  logic              enable_i,
    input  logic [DATA_W-1:0] compare_i,
    input  logic              load_i,
    input  logic [DATA_W-1:0] load_value_i,

    output logic [DATA_W-1:0] count_o,
    output logic              match_o
);

    logic [DATA_W-1:0] count_q;
    logic              match_q;
    logic              hit;

    assign hit = enable_i & ~load_i & (count_q == compare_i);

    // Load wins over counting; wrap to zero on match
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            count_q <= '0;
            match_q <= 1'b0;
        end else begin
            match_q <= hit;

            if (load_i) begin
                count_q <= load_value_i;
            end else if (hit) begin
                count_q <= '0;
            end else if (enable_i) begin
                count_q <= count_q + 1'b1;
            end
        end
    end

    assign count_o = count_q;
    assign match_o = match_q;

endmodule : timer_core

// File: src/timer_regs.sv
`timescale 1ns/1ps

module timer_regs import periph_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_n_i,

    input  logic              sel_i,
    input  apb_req_t          apb_req_i,
    input  logic [DATA_W-1:0] count_i,
    output logic [DATA_W-1:0] rdata_o,

    output logic              enable_o,
    output logic [DATA_W-1:0] compare_o,
    output logic              load_o,
    output logic [DATA_W-1:0] load_value_o
);

    timer_reg_e        offset;
    logic              wr_en;
    logic              enable_q;
    logic [DATA_W-1:0] compare_q;

    assign offset = timer_reg_e'(apb_req_i.paddr[3:2]);
    assign wr_en  = sel_i & apb_req_i.penable & apb_req_i.pwrite;

    // ==================================================
    // Control and compare registers
    // ==================================================

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            enable_q  <= 1'b0;
            compare_q <= '0;
        end else if (wr_en) begin
            case (offset)
                TMR_CTRL:    enable_q  <= apb_req_i.pwdata[0];
                TMR_COMPARE: compare_q <= apb_req_i.pwdata;
                default:     ;
            endcase
        end
    end

    // COUNT writes go straight to the counter at the same edge
    assign load_o       = wr_en & (offset == TMR_COUNT);
    assign load_value_o = apb_req_i.pwdata;

    assign enable_o  = enable_q;
    assign compare_o = compare_q;

    // Read mux
    always_comb begin
        rdata_o = '0;
        case (offset)
            TMR_CTRL:    rdata_o[0] = enable_q;
            TMR_COMPARE: rdata_o    = compare_q;
            TMR_COUNT:   rdata_o    = count_i;
            default:     rdata_o    = '0;
        endcase
    end

endmodule : timer_regs

// File: tb/periph_system_assert.sv
`timescale 1ns/1ps

module periph_system_assert import periph_pkg::*; (
    input logic     clk_i,
    input logic     rst_n_i,
    input apb_req_t apb_req_i,
    input apb_rsp_t apb_rsp_i,
    input logic     irq_i
);

    // Zero-wait slaves answer only in the access phase
    ready_in_access: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        apb_rsp_i.pready |-> (apb_req_i.psel && apb_req_i.penable)
    ) else $error("pready seen outside the APB access phase");

    err_with_ready: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        apb_rsp_i.pslverr |-> apb_rsp_i.pready
    ) else $error("pslverr seen without pready");

    irq_known: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !$isunknown(irq_i)
    ) else $error("irq_o is unknown after reset");

endmodule : periph_system_assert

bind periph_system periph_system_assert u_assert (
    .clk_i     ( clk_i     ),
    .rst_n_i   ( rst_n_i   ),
    .apb_req_i ( apb_req_i ),
    .apb_rsp_i ( apb_rsp_o ),
    .irq_i     ( irq_o     )
);

// File: tb/tb_periph_system.sv
`timescale 1ns/1ps

module tb_periph_system import periph_pkg::*; ();

    localparam int          CLK_PERIOD  = 100;
    localparam int          IRQ_TIMEOUT = 50;
    localparam int          IN_TIMEOUT  = 10;
    localparam logic [31:0] SEED        = 32'h5fbc_06eb;
    localparam logic [31:0] MEM_ADDR [4] = '{32'h0000_0000, 32'h0000_0004,
                                             32'h0000_03FC, 32'h0000_01A0};

    typedef struct {
        string       name;
        bit          write;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  strb;
        logic [31:0] exp_rdata;
        bit          exp_err;
    } step_t;

    logic                 clk;
    logic                 rst_n;
    apb_req_t             apb_req;
    apb_rsp_t             apb_rsp;
    logic [GPIO_PINS-1:0] gpio_in, gpio_out, gpio_oe;
    logic                 irq, irq_ack;
    logic [IRQ_VEC_W-1:0] irq_vector;

    step_t steps[$];
    int    checks = 0;
    int    errors = 0;

    periph_system UUT (
        .clk_i        ( clk        ),
        .rst_n_i      ( rst_n      ),
        .apb_req_i    ( apb_req    ),
        .apb_rsp_o    ( apb_rsp    ),
        .gpio_in_i    ( gpio_in    ),
        .gpio_out_o   ( gpio_out   ),
        .gpio_oe_o    ( gpio_oe    ),
        .irq_o        ( irq        ),
        .irq_vector_o ( irq_vector ),
        .irq_ack_i    ( irq_ack    )
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ==================================================
    // Helpers
    // ==================================================

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y ^= y << 13;
        y ^= y >> 17;
        y ^= y << 5;
        return y;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  strb);
        logic [31:0] result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                result[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return result;
    endfunction

    function automatic void add_step(input string name, input bit write, input logic [31:0] addr,
                                     input logic [31:0] wdata, input logic [3:0] strb,
                                     input logic [31:0] exp_rdata, input bit exp_err);
        step_t s;
        s.name      = name;
        s.write     = write;
        s.addr      = addr;
        s.wdata     = wdata;
        s.strb      = strb;
        s.exp_rdata = exp_rdata;
        s.exp_err   = exp_err;
        steps.push_back(s);
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error in %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
        end
    endtask

    // Setup and access phase, response sampled mid access phase
    task automatic apb_access(input bit write, input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [3:0] strb, output logic [31:0] rdata,
                              output logic err);
        @(negedge clk);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        apb_req.pstrb   = strb;
        @(negedge clk);
        apb_req.penable = 1'b1;
        #(CLK_PERIOD / 4);
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        check_value("pready in access phase", 32'd1, 32'(apb_rsp.pready));
        @(negedge clk);
        apb_req = '0;
    endtask

    task automatic write_reg(input logic [31:0] addr, input logic [31:0] wdata);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b1, addr, wdata, 4'hF, rdata, err);
    endtask

    task automatic read_reg(input logic [31:0] addr, output logic [31:0] rdata);
        logic err;
        apb_access(1'b0, addr, 32'd0, 4'h0, rdata, err);
    endtask

    task automatic ack_irq();
        @(negedge clk);
        irq_ack = 1'b1;
        @(negedge clk);
        irq_ack = 1'b0;
    endtask

    task automatic wait_vector(input irq_src_e vec, input string name);
        bit found;
        found = 1'b0;
        for (int c = 0; c < IRQ_TIMEOUT && !found; c++) begin
            @(negedge clk);
            found = (irq === 1'b1) && (irq_vector === vec);
        end
        if (!found) begin
            errors++;
            $display("Timeout in %s: irq did not rise with vector %0d within %0d cycles",
                     name, vec, IRQ_TIMEOUT);
        end
    endtask

    // Polls IN until the two-flop synchronizer has passed the value
    task automatic wait_gpio_in(input logic [GPIO_PINS-1:0] value);
        logic [31:0] rdata;
        bit          found;
        found = 1'b0;
        for (int c = 0; c < IN_TIMEOUT && !found; c++) begin
            read_reg(GPIO_BASE | 32'h8, rdata);
            found = (rdata === 32'(value));
        end
        if (!found) begin
            errors++;
            $display("Timeout: GPIO IN never returned 0x%02h within %0d reads", value, IN_TIMEOUT);
        end
    endtask

    // ==================================================
    // Stimulus
    // ==================================================

    initial begin
        logic [31:0] seed;
        logic [31:0] mem_words [4];
        logic [31:0] rdata;
        logic        err;

        rst_n   = 1'b0;
        apb_req = '0;
        gpio_in = '0;
        irq_ack = 1'b0;

        // Random words, then a partial strobe write merged here
        seed = SEED;
        for (int i = 0; i < 4; i++) begin
            seed         = xorshift(seed);
            mem_words[i] = seed;
            add_step("mem write", 1'b1, MEM_ADDR[i], seed, 4'hF, 32'd0, 1'b0);
        end
        for (int i = 0; i < 4; i++) begin
            add_step("mem read", 1'b0, MEM_ADDR[i], 32'd0, 4'h0, mem_words[i], 1'b0);
        end
        seed = xorshift(seed);
        add_step("mem strobe write", 1'b1, MEM_ADDR[1], seed, 4'b0101, 32'd0, 1'b0);
        add_step("mem strobe read", 1'b0, MEM_ADDR[1], 32'd0, 4'h0,
                 merge_bytes(mem_words[1], seed, 4'b0101), 1'b0);
        add_step("timer compare write", 1'b1, TIMER_BASE | 32'h4, 32'h1234_5678, 4'hF, 0, 1'b0);
        add_step("timer compare read", 1'b0, TIMER_BASE | 32'h4, 0, 4'h0, 32'h1234_5678, 1'b0);
        add_step("timer count write", 1'b1, TIMER_BASE | 32'h8, 32'h0000_00AB, 4'hF, 0, 1'b0);
        add_step("timer count read", 1'b0, TIMER_BASE | 32'h8, 0, 4'h0, 32'h0000_00AB, 1'b0);
        add_step("timer ctrl read", 1'b0, TIMER_BASE, 0, 4'h0, 32'd0, 1'b0);
        add_step("timer spare read", 1'b0, TIMER_BASE | 32'hC, 0, 4'h0, 32'd0, 1'b0);
        add_step("gpio out write", 1'b1, GPIO_BASE, 32'h0000_00A5, 4'hF, 0, 1'b0);
        add_step("gpio dir write", 1'b1, GPIO_BASE | 32'h4, 32'h0000_00F0, 4'hF, 0, 1'b0);
        add_step("gpio out read", 1'b0, GPIO_BASE, 0, 4'h0, 32'h0000_00A5, 1'b0);
        add_step("gpio dir read", 1'b0, GPIO_BASE | 32'h4, 0, 4'h0, 32'h0000_00F0, 1'b0);
        add_step("unmapped write", 1'b1, 32'h0000_5000, 32'hDEAD_BEEF, 4'hF, 0, 1'b1);
        add_step("unmapped read", 1'b0, 32'h0000_5000, 0, 4'h0, 32'd0, 1'b1);

        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        repeat (3) @(negedge clk);
        check_value("irq after reset", 32'd0, 32'(irq));
        check_value("gpio oe after reset", 32'd0, 32'(gpio_oe));

        foreach (steps[i]) begin
            apb_access(steps[i].write, steps[i].addr, steps[i].wdata, steps[i].strb, rdata, err);
            if (!steps[i].write) begin
                check_value(steps[i].name, steps[i].exp_rdata, rdata);
            end
            check_value({steps[i].name, " pslverr"}, 32'(steps[i].exp_err), 32'(err));
        end

        // Bus error interrupt from the unmapped accesses
        wait_vector(IRQ_BUS, "bus error irq");
        ack_irq();
        check_value("bus irq cleared", 32'd0, 32'(irq));

        // Timer match with a small compare
        write_reg(TIMER_BASE | 32'h4, 32'd5);
        write_reg(TIMER_BASE | 32'h8, 32'd0);
        write_reg(TIMER_BASE, 32'd1);
        wait_vector(IRQ_TIMER, "timer irq");
        read_reg(TIMER_BASE | 32'h8, rdata);
        check_value("timer count within compare", 32'd1, 32'(rdata <= 32'd5));
        write_reg(TIMER_BASE, 32'd0);
        repeat (3) @(negedge clk);
        ack_irq();
        check_value("timer irq cleared", 32'd0, 32'(irq));

        // GPIO pins, then an edge on an input pin
        check_value("gpio out pins", 32'h0000_00A5, 32'(gpio_out));
        check_value("gpio oe pins", 32'h0000_00F0, 32'(gpio_oe));
        @(negedge clk);
        gpio_in = 8'h30;
        wait_gpio_in(8'h30);
        check_value("no irq from output pins", 32'd0, 32'(irq));
        @(negedge clk);
        gpio_in = 8'h31;
        wait_vector(IRQ_GPIO, "gpio irq");
        ack_irq();
        check_value("gpio irq cleared", 32'd0, 32'(irq));

        // Timer and GPIO pending together
        @(negedge clk);
        gpio_in = 8'h33;
        wait_vector(IRQ_GPIO, "gpio irq before timer");
        write_reg(TIMER_BASE | 32'h4, 32'd3);
        write_reg(TIMER_BASE | 32'h8, 32'd0);
        write_reg(TIMER_BASE, 32'd1);
        wait_vector(IRQ_TIMER, "timer irq over gpio");
        write_reg(TIMER_BASE, 32'd0);
        repeat (3) @(negedge clk);
        check_value("priority vector first", 32'(IRQ_TIMER), 32'(irq_vector));
        ack_irq();
        check_value("priority irq still high", 32'd1, 32'(irq));
        check_value("priority vector second", 32'(IRQ_GPIO), 32'(irq_vector));
        ack_irq();
        check_value("priority irq cleared", 32'd0, 32'(irq));

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule : tb_periph_system

// File: vlog.f
src/periph_pkg.sv
src/apb_decoder.sv
src/sys_memory.sv
src/timer_regs.sv
src/timer_core.sv
src/gpio_port.sv
src/irq_controller.sv
src/periph_system.sv
tb/periph_system_assert.sv
tb/tb_periph_system.sv
